// ==== dv/program_patterns.hex ====
// record: word count / program words / expected exit_value_o / expected tests_passed_o
// opcode byte 01 LDI, 02 ADDI, 03 LOAD, 04 STORE, 05 BNEZ, 06 WFI; exit at 00010000
// arithmetic: LDI 5, ADDI 7, ADDI -12, exit
00000004
01000005 02000007 02FFFFF4 04010000
00000000 00000001
// load/store: LDI 0x1234, STORE 512, LDI 0, LOAD 512, ADDI -0x1234, exit
00000006
01001234 04000200 01000000 03000200 02FFEDCC 04010000
00000000 00000001
// loop: LDI 10, ADDI -1, BNEZ 1, LDI 0x55, exit
00000005
0100000A 02FFFFFF 05000001 01000055 04010000
00000055 00000000
// interrupt: LDI 30, STORE timer compare, WFI, LDI 0x77, exit
00000005
0100001E 04010004 06000000 01000077 04010000
00000077 00000000
// ram countdown: LDI 3, STORE 600, LOAD 600, ADDI -1, STORE 600, BNEZ 2, LOAD 600, exit
00000008
01000003 04000258 03000258 02FFFFFF 04000258 05000002 03000258 04010000
00000000 00000001
// end of list
00000000

// ==== compile.f ====
rtl/mini_sys_pkg.sv
rtl/sram_bank.sv
rtl/timer_irq.sv
rtl/acc_core.sv
rtl/mm_ram.sv
rtl/tb_subsystem.sv
dv/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log for the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

if ! verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f compile.f --top-module tb_top -o Vtb_top; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== dv/tb_top.sv ====
// testbench that runs each pattern file program on the mini subsystem and checks its exit outputs
`default_nettype none

module tb_top;

  timeunit 1ns;
  timeprecision 1ps;

  import mini_sys_pkg::*;

  localparam int    PAT_DEPTH    = 256;
  localparam int    NUM_PROGRAMS = 5;
  localparam int    RESET_CYCLES = 16;
  localparam int    IDLE_CYCLES  = 20;
  localparam int    HOLD_CYCLES  = 50;
  localparam int    EXIT_TIMEOUT = 2000;
  localparam string PAT_FILE     = "dv/program_patterns.hex";

  logic              clk;
  logic              rst;
  logic              fetch_enable;
  logic              tests_passed;
  logic              tests_failed;
  logic              exit_valid;
  logic [WORD_W-1:0] exit_value;

  // each record is a word count, the program words, the exit value and the pass flag
  logic [WORD_W-1:0] patterns [0:PAT_DEPTH-1];

  tb_subsystem uut (
    .clk_i         (clk),
    .rst_i         (rst),
    .fetch_enable_i(fetch_enable),
    .tests_passed_o(tests_passed),
    .tests_failed_o(tests_failed),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s at time %0t", reason, $time);
    $display("ERRORS FOUND");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [WORD_W-1:0] expected,
                             input logic [WORD_W-1:0] actual);
    assert (actual === expected) else begin
      $display("FAIL time %0t signal %s expected %h actual %h", $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "output mismatch");
    end
  endtask

  // nothing may report an exit before the core has run
  task automatic check_idle_outputs();
    check_value("exit_valid_o", '0, exit_valid);
    check_value("tests_passed_o", '0, tests_passed);
    check_value("tests_failed_o", '0, tests_failed);
  endtask

  task automatic load_program(input int base, input int count);
    logic [WORD_W-1:0] word;
    opcode_e           op;
    for (int i = 0; i < count; i++) begin
      word = patterns[base + i];
      op   = opcode_e'(word[WORD_W-1:WORD_W-OPCODE_W]);
      if (!(op inside {OP_LDI, OP_ADDI, OP_LOAD, OP_STORE, OP_BNEZ, OP_WFI})) begin
        abort_run("pattern file holds a program word with an unknown opcode");
      end else begin
        uut.ram_i.sram_i.mem[i] = word;
      end
    end
  endtask

  task automatic run_program(input int base, input int count,
                             input logic [WORD_W-1:0] exp_value, input logic exp_passed);
    int cycles;
    rst          = 1'b1;
    fetch_enable = 1'b0;
    load_program(base, count);
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst = 1'b0;
    // core must stay quiet until fetch is enabled
    for (int c = 0; c < IDLE_CYCLES; c++) begin
      @(negedge clk);
      check_idle_outputs();
    end
    fetch_enable = 1'b1;
    cycles       = 0;
    while (exit_valid !== 1'b1) begin
      if (cycles >= EXIT_TIMEOUT) begin
        abort_run("timeout while waiting for exit_valid_o to rise");
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
    check_value("exit_value_o", exp_value, exit_value);
    check_value("tests_passed_o", exp_passed, tests_passed);
    check_value("tests_failed_o", !exp_passed, tests_failed);
    // exit register holds while the core is parked
    for (int c = 0; c < HOLD_CYCLES; c++) begin
      @(negedge clk);
      check_value("exit_valid_o", 1'b1, exit_valid);
      check_value("exit_value_o", exp_value, exit_value);
      check_value("tests_passed_o", exp_passed, tests_passed);
      check_value("tests_failed_o", !exp_passed, tests_failed);
    end
    fetch_enable = 1'b0;
  endtask

  initial begin
    int ptr;
    int count;
    int prog;
    rst          = 1'b1;
    fetch_enable = 1'b0;
    for (int i = 0; i < PAT_DEPTH; i++) begin
      patterns[i] = '0;
    end
    $readmemh(PAT_FILE, patterns);
    ptr  = 0;
    prog = 0;
    @(negedge clk);
    // a zero word count ends the list
    while ((ptr < PAT_DEPTH) && (patterns[ptr] != '0)) begin
      count = int'(patterns[ptr]);
      if ((count > PAT_DEPTH - ptr - 3) || (count > 2 ** RAM_ADDR_WIDTH)) begin
        abort_run("pattern file holds a program that does not fit");
      end else begin
        run_program(ptr + 1, count, patterns[ptr + 1 + count], patterns[ptr + 2 + count][0]);
        ptr  = ptr + count + 3;
        prog = prog + 1;
      end
    end
    if (prog != NUM_PROGRAMS) begin
      abort_run("pattern file did not hold the expected number of programs");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tb_subsystem.sv ====
// test subsystem top joining the accumulator core, memory block and timer, driven by the testbench
`default_nettype none

module tb_subsystem (
  input  logic                            clk_i,
  input  logic                            rst_i,

  input  logic                            fetch_enable_i,
  output logic                            tests_passed_o,
  output logic                            tests_failed_o,
  output logic                            exit_valid_o,
  output logic [mini_sys_pkg::WORD_W-1:0] exit_value_o
);

  import mini_sys_pkg::*;

  // instruction port
  logic              instr_req;
  logic              instr_gnt;
  logic              instr_rvalid;
  logic [WORD_W-1:0] instr_addr;
  logic [WORD_W-1:0] instr_rdata;

  // data port
  logic              data_req;
  logic              data_gnt;
  logic              data_rvalid;
  logic              data_we;
  logic [WORD_W-1:0] data_addr;
  logic [WORD_W-1:0] data_wdata;
  logic [WORD_W-1:0] data_rdata;

  // timer and interrupt
  logic              timer_cmp_we;
  logic [WORD_W-1:0] timer_cmp_value;
  logic              irq_timer;
  logic              irq_ack;

  acc_core core_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_enable_i(fetch_enable_i),
    .instr_req_o   (instr_req),
    .instr_addr_o  (instr_addr),
    .instr_gnt_i   (instr_gnt),
    .instr_rvalid_i(instr_rvalid),
    .instr_rdata_i (instr_rdata),
    .data_req_o    (data_req),
    .data_we_o     (data_we),
    .data_addr_o   (data_addr),
    .data_wdata_o  (data_wdata),
    .data_gnt_i    (data_gnt),
    .data_rvalid_i (data_rvalid),
    .data_rdata_i  (data_rdata),
    .irq_timer_i   (irq_timer),
    .irq_ack_o     (irq_ack),
    .exit_valid_i  (exit_valid_o)
  );

  mm_ram ram_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .instr_req_i      (instr_req),
    .instr_addr_i     (instr_addr),
    .instr_gnt_o      (instr_gnt),
    .instr_rvalid_o   (instr_rvalid),
    .instr_rdata_o    (instr_rdata),
    .data_req_i       (data_req),
    .data_we_i        (data_we),
    .data_addr_i      (data_addr),
    .data_wdata_i     (data_wdata),
    .data_gnt_o       (data_gnt),
    .data_rvalid_o    (data_rvalid),
    .data_rdata_o     (data_rdata),
    .timer_cmp_we_o   (timer_cmp_we),
    .timer_cmp_value_o(timer_cmp_value),
    .tests_passed_o   (tests_passed_o),
    .tests_failed_o   (tests_failed_o),
    .exit_valid_o     (exit_valid_o),
    .exit_value_o     (exit_value_o)
  );

  timer_irq timer_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cmp_we_i   (timer_cmp_we),
    .cmp_value_i(timer_cmp_value),
    .irq_ack_i  (irq_ack),
    .irq_timer_o(irq_timer)
  );

endmodule

`default_nettype wire

// ==== rtl/mm_ram.sv ====
// memory block serving instruction and data ports from one RAM, with exit and timer compare registers
`default_nettype none

module mm_ram (
  input  logic                            clk_i,
  input  logic                            rst_i,

  input  logic                            instr_req_i,
  input  logic [mini_sys_pkg::WORD_W-1:0] instr_addr_i,
  output logic                            instr_gnt_o,
  output logic                            instr_rvalid_o,
  output logic [mini_sys_pkg::WORD_W-1:0] instr_rdata_o,

  input  logic                            data_req_i,
  input  logic                            data_we_i,
  input  logic [mini_sys_pkg::WORD_W-1:0] data_addr_i,
  input  logic [mini_sys_pkg::WORD_W-1:0] data_wdata_i,
  output logic                            data_gnt_o,
  output logic                            data_rvalid_o,
  output logic [mini_sys_pkg::WORD_W-1:0] data_rdata_o,

  output logic                            timer_cmp_we_o,
  output logic [mini_sys_pkg::WORD_W-1:0] timer_cmp_value_o,

  output logic                            tests_passed_o,
  output logic                            tests_failed_o,
  output logic                            exit_valid_o,
  output logic [mini_sys_pkg::WORD_W-1:0] exit_value_o
);

  import mini_sys_pkg::*;

  logic              sel_ram;
  logic              sel_exit;
  logic              sel_tcmp;
  logic              rsel_ram_q;
  logic [WORD_W-1:0] ram_rdata;

  // address decode on the data port
  assign sel_ram  = (data_addr_i[WORD_W-1:RAM_ADDR_WIDTH] == '0);
  assign sel_exit = (data_addr_i == EXIT_ADDR);
  assign sel_tcmp = (data_addr_i == TIMER_CMP_ADDR);

  // no back-pressure on either port
  assign instr_gnt_o = instr_req_i;
  assign data_gnt_o  = data_req_i;

  sram_bank sram_i (
    .clk_i        (clk_i),
    .instr_en_i   (instr_req_i),
    .instr_waddr_i(instr_addr_i[RAM_ADDR_WIDTH-1:0]),
    .instr_rdata_o(instr_rdata_o),
    .data_en_i    (data_req_i && sel_ram),
    .data_we_i    (data_we_i),
    .data_waddr_i (data_addr_i[RAM_ADDR_WIDTH-1:0]),
    .data_wdata_i (data_wdata_i),
    .data_rdata_o (ram_rdata)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      instr_rvalid_o <= 1'b0;
      data_rvalid_o  <= 1'b0;
      rsel_ram_q     <= 1'b0;
    end else begin
      instr_rvalid_o <= instr_req_i;
      data_rvalid_o  <= data_req_i;
      rsel_ram_q     <= sel_ram;
    end
  end

  // peripherals read back as zero
  assign data_rdata_o = rsel_ram_q ? ram_rdata : '0;

  assign timer_cmp_we_o    = data_req_i && data_we_i && sel_tcmp;
  assign timer_cmp_value_o = data_wdata_i;

  // exit register latches the first store and holds until reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_o <= 1'b0;
    end else if (data_req_i && data_we_i && sel_exit) begin
      exit_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_req_i && data_we_i && sel_exit && !exit_valid_o) begin
      exit_value_o <= data_wdata_i;
    end
  end

  assign tests_passed_o = exit_valid_o && (exit_value_o == '0);
  assign tests_failed_o = exit_valid_o && (exit_value_o != '0);

  // programs only touch RAM and the two mapped registers
  a_data_addr_mapped: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_i |-> (sel_ram || sel_exit || sel_tcmp));

  a_instr_addr_in_ram: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_i |-> (instr_addr_i[WORD_W-1:RAM_ADDR_WIDTH] == '0));

endmodule

`default_nettype wire

// ==== rtl/acc_core.sv ====
// multi-cycle accumulator core with instruction and data req/gnt/rvalid ports, used as the DUT CPU
`default_nettype none

module acc_core (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             fetch_enable_i,

  output logic                             instr_req_o,
  output logic [mini_sys_pkg::WORD_W-1:0]  instr_addr_o,
  input  logic                             instr_gnt_i,
  input  logic                             instr_rvalid_i,
  input  logic [mini_sys_pkg::WORD_W-1:0]  instr_rdata_i,

  output logic                             data_req_o,
  output logic                             data_we_o,
  output logic [mini_sys_pkg::WORD_W-1:0]  data_addr_o,
  output logic [mini_sys_pkg::WORD_W-1:0]  data_wdata_o,
  input  logic                             data_gnt_i,
  input  logic                             data_rvalid_i,
  input  logic [mini_sys_pkg::WORD_W-1:0]  data_rdata_i,

  input  logic                             irq_timer_i,
  output logic                             irq_ack_o,

  input  logic                             exit_valid_i
);

  import mini_sys_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    FETCH_WAIT,
    EXECUTE,
    MEM_WAIT,
    WFI,
    DONE
  } state_e;

  state_e            state_q;
  logic [WORD_W-1:0] pc_q;
  logic [WORD_W-1:0] acc_q;
  logic [WORD_W-1:0] instr_q;
  logic [WORD_W-1:0] pc_inc;

  opcode_e           op;
  logic [IMM_W-1:0]  imm;
  logic [WORD_W-1:0] imm_zext;
  logic [WORD_W-1:0] imm_sext;

  // decode fields of the latched instruction
  assign op       = opcode_e'(instr_q[WORD_W-1:IMM_W]);
  assign imm      = instr_q[IMM_W-1:0];
  assign imm_zext = {{(WORD_W - IMM_W){1'b0}}, imm};
  assign imm_sext = {{(WORD_W - IMM_W){imm[IMM_W-1]}}, imm};
  assign pc_inc   = pc_q + 1'b1;

  // bus requests are decoded from the current state
  assign instr_req_o  = (state_q == FETCH);
  assign instr_addr_o = pc_q;

  assign data_req_o   = (state_q == EXECUTE) && ((op == OP_LOAD) || (op == OP_STORE));
  assign data_we_o    = (op == OP_STORE);
  assign data_addr_o  = imm_zext;
  assign data_wdata_o = acc_q;

  // one-cycle ack as the core leaves WFI
  assign irq_ack_o = (state_q == WFI) && irq_timer_i;

  always_ff @(posedge clk_i) begin
    if ((state_q == FETCH_WAIT) && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      pc_q    <= BOOT_ADDR;
      acc_q   <= '0;
    end else if (exit_valid_i) begin
      // park the core once the test has ended
      state_q <= DONE;
    end else begin
      case (state_q)
        IDLE: begin
          if (fetch_enable_i) begin
            state_q <= FETCH;
          end
        end
        FETCH: begin
          if (instr_gnt_i) begin
            state_q <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (instr_rvalid_i) begin
            state_q <= EXECUTE;
          end
        end
        EXECUTE: begin
          case (op)
            OP_LDI: begin
              acc_q   <= imm_zext;
              pc_q    <= pc_inc;
              state_q <= FETCH;
            end
            OP_ADDI: begin
              acc_q   <= acc_q + imm_sext;
              pc_q    <= pc_inc;
              state_q <= FETCH;
            end
            OP_BNEZ: begin
              pc_q    <= (acc_q != '0) ? imm_zext : pc_inc;
              state_q <= FETCH;
            end
            OP_LOAD, OP_STORE: begin
              if (data_gnt_i) begin
                state_q <= MEM_WAIT;
              end
            end
            OP_WFI: begin
              state_q <= WFI;
            end
            default: begin
              // unknown opcode executes as a nop
              pc_q    <= pc_inc;
              state_q <= FETCH;
            end
          endcase
        end
        MEM_WAIT: begin
          if (data_rvalid_i) begin
            if (op == OP_LOAD) begin
              acc_q <= data_rdata_i;
            end
            pc_q    <= pc_inc;
            state_q <= FETCH;
          end
        end
        WFI: begin
          if (irq_timer_i) begin
            pc_q    <= pc_inc;
            state_q <= FETCH;
          end
        end
        DONE: begin
          state_q <= DONE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // a granted request gets its rvalid one cycle later
  // and the core raises no new request before it
  a_instr_one_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_o && instr_gnt_i |=> instr_rvalid_i && !instr_req_o);

  a_data_one_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_o && data_gnt_i |=> data_rvalid_i && !data_req_o);

  // program image must hold only known opcodes
  a_known_opcode: assert property (@(posedge clk_i) disable iff (rst_i)
    state_q == EXECUTE |-> op inside {OP_LDI, OP_ADDI, OP_LOAD, OP_STORE, OP_BNEZ, OP_WFI});

endmodule

`default_nettype wire

// ==== rtl/timer_irq.sv ====
// free-running cycle timer with a relative compare, raising a level interrupt until acknowledged
`default_nettype none

module timer_irq (
  input  logic                            clk_i,
  input  logic                            rst_i,

  input  logic                            cmp_we_i,
  input  logic [mini_sys_pkg::WORD_W-1:0] cmp_value_i,

  input  logic                            irq_ack_i,
  output logic                            irq_timer_o
);

  import mini_sys_pkg::*;

  logic [WORD_W-1:0] count_q;
  logic [WORD_W-1:0] cmp_q;
  logic              armed_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  // compare value is relative to the count at the write
  always_ff @(posedge clk_i) begin
    if (cmp_we_i) begin
      cmp_q <= count_q + cmp_value_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      armed_q     <= 1'b0;
      irq_timer_o <= 1'b0;
    end else if (cmp_we_i) begin
      armed_q     <= 1'b1;
      irq_timer_o <= 1'b0;
    end else if (irq_ack_i) begin
      armed_q     <= 1'b0;
      irq_timer_o <= 1'b0;
    end else if (armed_q && (count_q == cmp_q)) begin
      // level stays up until the core acks
      irq_timer_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sram_bank.sv ====
// word RAM with a registered instruction read port and a registered data read/write port
`default_nettype none

module sram_bank (
  input  logic                                    clk_i,

  input  logic                                    instr_en_i,
  input  logic [mini_sys_pkg::RAM_ADDR_WIDTH-1:0] instr_waddr_i,
  output logic [mini_sys_pkg::WORD_W-1:0]         instr_rdata_o,

  input  logic                                    data_en_i,
  input  logic                                    data_we_i,
  input  logic [mini_sys_pkg::RAM_ADDR_WIDTH-1:0] data_waddr_i,
  input  logic [mini_sys_pkg::WORD_W-1:0]         data_wdata_i,
  output logic [mini_sys_pkg::WORD_W-1:0]         data_rdata_o
);

  import mini_sys_pkg::*;

  localparam int unsigned DEPTH = 2 ** RAM_ADDR_WIDTH;

  // testbench preloads this array while the design is in reset
  logic [WORD_W-1:0] mem [0:DEPTH-1];

  always @(posedge clk_i) begin
    if (data_en_i && data_we_i) begin
      mem[data_waddr_i] <= data_wdata_i;
    end
  end

  // both reads see the word as it was before a same-edge write
  always_ff @(posedge clk_i) begin
    if (instr_en_i) begin
      instr_rdata_o <= mem[instr_waddr_i];
    end
    if (data_en_i) begin
      data_rdata_o <= mem[data_waddr_i];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mini_sys_pkg.sv ====
// shared sizes, opcodes and peripheral addresses for the mini test subsystem and its testbench
`default_nettype none

package mini_sys_pkg;

  // data and address width of both bus ports
  localparam int unsigned WORD_W = 32;

  // RAM is 1024 words, word addressed
  localparam int unsigned RAM_ADDR_WIDTH = 10;

  // instruction split into opcode byte and immediate/address field
  localparam int unsigned OPCODE_W = 8;
  localparam int unsigned IMM_W = WORD_W - OPCODE_W;

  // fetch starts here after reset
  localparam logic [WORD_W-1:0] BOOT_ADDR = 32'h0000_0000;

  // memory mapped pseudo peripherals on the data port
  localparam logic [WORD_W-1:0] EXIT_ADDR = 32'h0001_0000;
  localparam logic [WORD_W-1:0] TIMER_CMP_ADDR = 32'h0001_0004;

  // opcodes live in the top byte of each instruction word
  typedef enum logic [OPCODE_W-1:0] {
    OP_LDI   = 8'h01,
    OP_ADDI  = 8'h02,
    OP_LOAD  = 8'h03,
    OP_STORE = 8'h04,
    OP_BNEZ  = 8'h05,
    OP_WFI   = 8'h06
  } opcode_e;

endpackage

`default_nettype wire
